// ==== files.f ====
+incdir+include
hw/lenet_pkg.sv
hw/lenet_approx_mul8.sv
hw/lenet_mac_engine.sv
hw/lenet_wb_arbiter.sv
hw/lenet_scratch_ram.sv
hw/lenet_mac_top.sv
verification/lenet_mac_sva.sv
verification/lenet_mac_tb.sv

// ==== hw/lenet_approx_mul8.sv ====
module lenet_approx_mul8 (
    input  logic [7:0]  x,
    input  logic [7:0]  y,
    output logic [15:0] z
);

    // pp[i] is the row for x[i], weight 2**i
    logic [7:0]  pp [8];
    logic [12:0] term [6];
    logic [15:0] exact_hi;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // the two top rows carry most of the product and stay exact
    assign exact_hi = 16'({pp[6], 6'b0}) + 16'({pp[7], 7'b0});

    // ------------------------------
    // compressed low rows
    // ------------------------------

    // pairs of bits from rows 0 to 5 are merged with and, or and xor
    // instead of being added, most bit positions are simply dropped
    always_comb begin
        for (int k = 0; k < 6; k++) begin
            term[k] = '0;
        end

        term[0][2]  = pp[0][1] & pp[1][0];
        term[0][5]  = pp[0][5] & pp[1][4];
        term[0][6]  = pp[0][5] ^ pp[1][4];
        term[0][7]  = pp[0][7] | pp[1][6];
        term[0][8]  = pp[0][7] & pp[1][6];
        term[0][9]  = pp[2][6] | pp[3][5];
        term[0][10] = pp[3][7];
        term[0][11] = pp[4][7] & pp[5][6];
        term[0][12] = pp[5][7];

        term[1][5]  = pp[4][1] & pp[5][0];
        term[1][6]  = pp[2][4] & pp[3][3];
        term[1][7]  = pp[4][3] | pp[5][2];
        term[1][8]  = pp[1][7];
        term[1][9]  = pp[2][7] ^ pp[3][6];
        term[1][10] = pp[4][5] & pp[5][4];
        term[1][11] = pp[4][7] | pp[5][6];

        term[2][6]  = pp[2][4] ^ pp[3][3];
        term[2][8]  = pp[2][6] & pp[3][5];
        term[2][9]  = pp[4][4] & pp[5][3];
        term[2][10] = pp[4][6] | pp[5][5];

        term[3][6]  = pp[4][1] & pp[5][0];
        term[3][9]  = pp[4][4] ^ pp[5][3];

        // rows 4 and 5 at bit 9 are counted a second time here
        term[4][9]  = pp[4][5] & pp[5][4];
        term[5][9]  = pp[4][5] | pp[5][4];
    end

    // ------------------------------
    // final sum
    // ------------------------------

    always_comb begin
        z = exact_hi;
        for (int k = 0; k < 6; k++) begin
            z = z + 16'(term[k]);
        end
    end

endmodule

// ==== hw/lenet_mac_engine.sv ====
`include "lenet_macros.svh"

module lenet_mac_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  lenet_pkg::mac_job_t job,
    output logic                done,
    output lenet_pkg::wb_req_t  wb_req,
    input  lenet_pkg::wb_rsp_t  wb_rsp
);

    typedef enum logic [2:0] {
        st_idle,
        st_rd_pix,
        st_rd_wgt,
        st_acc,
        st_write,
        st_done
    } state_t;

    state_t                     state;
    logic                       bus_act;
    logic                       xfer_done;
    logic [`LENET_ADDR_W-1:0]   pix_ptr;
    logic [`LENET_ADDR_W-1:0]   wgt_ptr;
    logic [`LENET_ADDR_W-1:0]   dst_ptr;
    logic [`LENET_COUNT_W-1:0]  remaining;
    lenet_pkg::mem_word_u       pix_word;
    lenet_pkg::mem_word_u       wgt_word;
    lenet_pkg::mem_word_u       acc_word;
    logic [15:0]                prod [`LENET_LANES];
    logic [17:0]                lane_sum;

    // ------------------------------
    // multiplier lanes
    // ------------------------------

    for (genvar g = 0; g < `LENET_LANES; g++) begin : g_lane
        lenet_approx_mul8 u_mul (
            .x (wgt_word.lanes[g]),
            .y (pix_word.lanes[g]),
            .z (prod[g])
        );
    end

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `LENET_LANES; i++) begin
            lane_sum = lane_sum + 18'(prod[i]);
        end
    end

    // ------------------------------
    // wishbone master
    // ------------------------------

    // adr and dat follow the state, which holds until ack
    always_comb begin
        wb_req.cyc = bus_act;
        wb_req.stb = bus_act;
        wb_req.we  = (state == st_write);
        wb_req.dat = acc_word;
        case (state)
            st_rd_wgt: wb_req.adr = wgt_ptr;
            st_write:  wb_req.adr = dst_ptr;
            default:   wb_req.adr = pix_ptr;
        endcase
    end

    assign xfer_done = bus_act && wb_rsp.ack;
    assign done = (state == st_done);

    // every bus state raises cyc one cycle after entry, so the bus sees a
    // low cyc between two transfers and the arbiter can regrant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            bus_act <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= (job.count == '0) ? st_write : st_rd_pix;
                    end
                end
                st_rd_pix, st_rd_wgt, st_write: begin
                    if (!bus_act) begin
                        bus_act <= 1'b1;
                    end else if (wb_rsp.ack) begin
                        bus_act <= 1'b0;
                        case (state)
                            st_rd_pix: state <= st_rd_wgt;
                            st_rd_wgt: state <= st_acc;
                            default:   state <= st_done;
                        endcase
                    end
                end
                st_acc: begin
                    state <= (remaining == 1) ? st_write : st_rd_pix;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            pix_ptr      <= job.src_adr;
            wgt_ptr      <= job.wgt_adr;
            dst_ptr      <= job.dst_adr;
            remaining    <= job.count;
            acc_word.acc <= '0;
        end
        if (state == st_rd_pix && xfer_done) begin
            pix_word <= wb_rsp.dat;
        end
        if (state == st_rd_wgt && xfer_done) begin
            wgt_word <= wb_rsp.dat;
        end
        if (state == st_acc) begin
            acc_word.acc <= acc_word.acc + `LENET_DATA_W'(lane_sum);
            pix_ptr      <= pix_ptr + 1'b1;
            wgt_ptr      <= wgt_ptr + 1'b1;
            remaining    <= remaining - 1'b1;
        end
    end

endmodule

// ==== hw/lenet_mac_top.sv ====
module lenet_mac_top (
    input  logic                clk,
    input  logic                rst_n,
    input  lenet_pkg::wb_req_t  host_req,
    output lenet_pkg::wb_rsp_t  host_rsp,
    input  lenet_pkg::mac_job_t job0,
    input  logic                start0,
    output logic                done0,
    input  lenet_pkg::mac_job_t job1,
    input  logic                start1,
    output logic                done1
);

    lenet_pkg::wb_req_t eng_req [2];
    lenet_pkg::wb_rsp_t eng_rsp [2];
    lenet_pkg::wb_req_t m_req [3];
    lenet_pkg::wb_rsp_t m_rsp [3];
    lenet_pkg::wb_req_t ram_req;
    lenet_pkg::wb_rsp_t ram_rsp;

    // host is master 0, engines follow
    assign m_req[0]   = host_req;
    assign m_req[1]   = eng_req[0];
    assign m_req[2]   = eng_req[1];
    assign host_rsp   = m_rsp[0];
    assign eng_rsp[0] = m_rsp[1];
    assign eng_rsp[1] = m_rsp[2];

    lenet_mac_engine u_eng0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start0),
        .job    (job0),
        .done   (done0),
        .wb_req (eng_req[0]),
        .wb_rsp (eng_rsp[0])
    );

    lenet_mac_engine u_eng1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start1),
        .job    (job1),
        .done   (done1),
        .wb_req (eng_req[1]),
        .wb_rsp (eng_rsp[1])
    );

    lenet_wb_arbiter #(
        .n_masters (3)
    ) u_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .s_req (ram_req),
        .s_rsp (ram_rsp)
    );

    lenet_scratch_ram u_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (ram_req),
        .wb_rsp (ram_rsp)
    );

endmodule

// ==== hw/lenet_pkg.sv ====
`include "lenet_macros.svh"

package lenet_pkg;

    // ------------------------------
    // wishbone classic
    // ------------------------------

    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`LENET_ADDR_W-1:0]   adr;
        logic [`LENET_DATA_W-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic                       ack;
        logic [`LENET_DATA_W-1:0]   dat;
    } wb_rsp_t;

    // ------------------------------
    // engine job and memory word
    // ------------------------------

    // count is in words, each word holds one pixel or weight per lane
    typedef struct packed {
        logic [`LENET_ADDR_W-1:0]   src_adr;
        logic [`LENET_ADDR_W-1:0]   wgt_adr;
        logic [`LENET_COUNT_W-1:0]  count;
        logic [`LENET_ADDR_W-1:0]   dst_adr;
    } mac_job_t;

    // a scratchpad word is either four operand bytes or one result
    typedef union packed {
        logic [`LENET_LANES-1:0][7:0]   lanes;
        logic [`LENET_DATA_W-1:0]       acc;
    } mem_word_u;

endpackage

// ==== hw/lenet_scratch_ram.sv ====
`include "lenet_macros.svh"

module lenet_scratch_ram (
    input  logic               clk,
    input  logic               rst_n,
    input  lenet_pkg::wb_req_t wb_req,
    output lenet_pkg::wb_rsp_t wb_rsp
);

    localparam int depth = 1 << `LENET_ADDR_W;

    logic [`LENET_DATA_W-1:0] mem [depth];
    logic [`LENET_DATA_W-1:0] rd_q;
    logic                     ack_q;
    logic                     access;

    // no new access in the ack cycle, the master drops stb only after it
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_req.we) begin
                mem[wb_req.adr] <= wb_req.dat;
            end
            rd_q <= mem[wb_req.adr];
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;

endmodule

// ==== hw/lenet_wb_arbiter.sv ====
module lenet_wb_arbiter #(
    parameter int n_masters = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  lenet_pkg::wb_req_t m_req [n_masters],
    output lenet_pkg::wb_rsp_t m_rsp [n_masters],
    output lenet_pkg::wb_req_t s_req,
    input  lenet_pkg::wb_rsp_t s_rsp
);

    localparam int idx_w = (n_masters > 1) ? $clog2(n_masters) : 1;

    logic             gnt_valid;
    logic [idx_w-1:0] last_owner;
    logic [idx_w-1:0] next_owner;
    logic             any_req;

    // scan from the master after the last owner, the nearest one wins
    always_comb begin
        int cand;
        next_owner = last_owner;
        any_req    = 1'b0;
        for (int off = n_masters; off >= 1; off--) begin
            cand = int'(last_owner) + off;
            if (cand >= n_masters) begin
                cand = cand - n_masters;
            end
            if (m_req[cand].cyc) begin
                next_owner = idx_w'(cand);
                any_req    = 1'b1;
            end
        end
    end

    // last_owner doubles as the current owner while the grant is held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt_valid  <= 1'b0;
            last_owner <= '0;
        end else if (gnt_valid) begin
            if (!m_req[last_owner].cyc) begin
                gnt_valid <= 1'b0;
            end
        end else if (any_req) begin
            gnt_valid  <= 1'b1;
            last_owner <= next_owner;
        end
    end

    // ------------------------------
    // routing
    // ------------------------------

    always_comb begin
        s_req = '0;
        if (gnt_valid) begin
            s_req = m_req[last_owner];
        end
        for (int i = 0; i < n_masters; i++) begin
            m_rsp[i] = '0;
            if (gnt_valid && last_owner == idx_w'(i)) begin
                m_rsp[i] = s_rsp;
            end
        end
    end

endmodule

// ==== include/lenet_macros.svh ====
`ifndef LENET_MACROS_SVH
`define LENET_MACROS_SVH

// ------------------------------
// scratchpad and bus geometry
// ------------------------------

// word address width, 256 words of scratchpad
`define LENET_ADDR_W 8

// one bus word, also one accumulator
`define LENET_DATA_W 32

// byte lanes carried in one bus word
`define LENET_LANES 4

// width of the word count in a job
`define LENET_COUNT_W 8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module lenet_mac_tb -Mdir "$build_dir" -o lenet_mac_sim -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running after an assertion error so the testbench can report
"./$build_dir/lenet_mac_sim" +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== verification/lenet_mac_sva.sv ====
module lenet_mac_sva (
    input logic               clk,
    input logic               rst_n,
    input lenet_pkg::wb_req_t m_req [3],
    input lenet_pkg::wb_rsp_t m_rsp [3],
    input lenet_pkg::wb_req_t ram_req,
    input lenet_pkg::wb_rsp_t ram_rsp,
    input logic               done0,
    input logic               done1
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // ------------------------------
    // bus rules
    // ------------------------------

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        ram_rsp.ack |-> ram_req.cyc && ram_req.stb)
        else begin
            fail_count++;
            $error("ram ack seen without cyc and stb");
        end

    one_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({m_rsp[2].ack, m_rsp[1].ack, m_rsp[0].ack}))
        else begin
            fail_count++;
            $error("more than one master saw ack");
        end

    // a waiting master keeps its request frozen
    for (genvar i = 0; i < 3; i++) begin : g_hold
        req_hold: assert property (@(posedge clk) disable iff (!rst_n)
            m_req[i].stb && !m_rsp[i].ack |=>
                m_req[i].stb && $stable(m_req[i].adr) && $stable(m_req[i].dat))
            else begin
                fail_count++;
                $error("master %0d changed its request before ack", i);
            end
    end

    // ------------------------------
    // engine handshake and reset
    // ------------------------------

    done0_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done0 |=> !done0)
        else begin
            fail_count++;
            $error("done0 held longer than one cycle");
        end

    done1_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done1 |=> !done1)
        else begin
            fail_count++;
            $error("done1 held longer than one cycle");
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !ram_req.cyc && !m_req[1].cyc && !m_req[2].cyc && !ram_rsp.ack
                   && !done0 && !done1)
        else begin
            fail_count++;
            $error("bus or done active right after reset");
        end

endmodule

bind lenet_mac_top lenet_mac_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .m_req   (m_req),
    .m_rsp   (m_rsp),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp),
    .done0   (done0),
    .done1   (done1)
);

// ==== verification/lenet_mac_tb.sv ====
`include "lenet_macros.svh"

module lenet_mac_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int wait_limit = 200;

    logic                     clk;
    logic                     rst_n;
    lenet_pkg::wb_req_t       host_req;
    lenet_pkg::wb_rsp_t       host_rsp;
    lenet_pkg::mac_job_t      job0;
    lenet_pkg::mac_job_t      job1;
    logic                     start0;
    logic                     start1;
    logic                     done0;
    logic                     done1;
    logic [31:0]              rng;
    logic [`LENET_DATA_W-1:0] shadow [1 << `LENET_ADDR_W];
    int                       errors;

    lenet_mac_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ------------------------------
    // host bus access
    // ------------------------------

    task automatic host_xfer(input logic we, input logic [`LENET_ADDR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        rdat = '0;
        waited = 0;
        do begin
            @(posedge clk);
            #5;
            waited++;
        end while (!host_rsp.ack && waited < wait_limit);
        if (host_rsp.ack) begin
            rdat = host_rsp.dat;
            if (we) begin
                shadow[adr] = wdat;
            end
        end else begin
            errors++;
            $display("Timeout: no ack for host access to address %h", adr);
        end
        // the request drops after the ack edge and cyc stays low for a cycle
        // so that the arbiter can regrant
        @(posedge clk);
        #5;
        host_req = '0;
        @(posedge clk);
        #5;
    endtask

    task automatic check_read(input logic [`LENET_ADDR_W-1:0] adr, input logic [31:0] exp,
                              input string what);
        logic [31:0] got;
        host_xfer(1'b0, adr, '0, got);
        assert (got == exp) else begin
            errors++;
            $display("Mismatch host_rsp.dat (%s) at %h: expected %h, got %h",
                     what, adr, exp, got);
        end
    endtask

    // ------------------------------
    // engine jobs
    // ------------------------------

    // weight bytes only use bits 6 and 7, so every lane product is exact
    task automatic load_operands(input lenet_pkg::mac_job_t job, input bit zero_wgt,
                                 output logic [31:0] sum);
        logic [31:0] pix;
        logic [31:0] wgt;
        logic [31:0] unused;
        sum = '0;
        for (int w = 0; w < int'(job.count); w++) begin
            rng = xorshift32(rng);
            pix = rng;
            rng = xorshift32(rng);
            wgt = zero_wgt ? '0 : (rng & 32'hc0c0_c0c0);
            host_xfer(1'b1, job.src_adr + `LENET_ADDR_W'(w), pix, unused);
            host_xfer(1'b1, job.wgt_adr + `LENET_ADDR_W'(w), wgt, unused);
            for (int l = 0; l < `LENET_LANES; l++) begin
                sum = sum + 32'(wgt[8*l +: 8]) * 32'(pix[8*l +: 8]);
            end
        end
    endtask

    task automatic pulse_start(input bit s0, input bit s1);
        start0 = s0;
        start1 = s1;
        @(posedge clk);
        #5;
        start0 = 1'b0;
        start1 = 1'b0;
    endtask

    task automatic wait_done(input int eng);
        int waited;
        waited = 0;
        while (!(eng == 0 ? done0 : done1) && waited < wait_limit) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (!(eng == 0 ? done0 : done1)) begin
            errors++;
            $display("Timeout: engine %0d did not finish its job", eng);
        end
    endtask

    task automatic run_single(input lenet_pkg::mac_job_t job, input bit zero_wgt);
        logic [31:0] sum;
        logic [31:0] unused;
        load_operands(job, zero_wgt, sum);
        // stale data at the result address has to be overwritten
        host_xfer(1'b1, job.dst_adr, 32'hdead_beef, unused);
        job0 = job;
        pulse_start(1'b1, 1'b0);
        wait_done(0);
        check_read(job.dst_adr, sum, "engine 0 result");
    endtask

    task automatic run_contention(input logic [`LENET_ADDR_W-1:0] poll_adr);
        logic [31:0] sum0;
        logic [31:0] sum1;
        bit          fin0;
        bit          fin1;
        int          polls;
        job0 = '{src_adr: 8'h30, wgt_adr: 8'h38, count: 8'd4, dst_adr: 8'h24};
        job1 = '{src_adr: 8'h40, wgt_adr: 8'h48, count: 8'd3, dst_adr: 8'h25};
        load_operands(job0, 1'b0, sum0);
        load_operands(job1, 1'b0, sum1);
        fin0 = 1'b0;
        fin1 = 1'b0;
        polls = 0;
        pulse_start(1'b1, 1'b1);
        fork
            begin
                wait_done(0);
                fin0 = 1'b1;
            end
            begin
                wait_done(1);
                fin1 = 1'b1;
            end
            while (!(fin0 && fin1) && polls < wait_limit) begin
                check_read(poll_adr, shadow[poll_adr], "host poll");
                polls++;
            end
        join
        check_read(job0.dst_adr, sum0, "engine 0 result");
        check_read(job1.dst_adr, sum1, "engine 1 result");
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        logic [`LENET_ADDR_W-1:0] adrs [8];
        logic [31:0]              unused;
        lenet_pkg::mac_job_t      job;
        int                       sva_fails;
        rng = 32'd8307;
        errors = 0;
        rst_n = 1'b0;
        host_req = '0;
        job0 = '0;
        job1 = '0;
        start0 = 1'b0;
        start1 = 1'b0;
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;

        // random words go to the upper half and stay clear of all job data
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            adrs[i] = {1'b1, rng[6:0]};
            rng = xorshift32(rng);
            host_xfer(1'b1, adrs[i], rng, unused);
        end
        for (int i = 0; i < 8; i++) begin
            check_read(adrs[i], shadow[adrs[i]], "host word");
        end

        job = '{src_adr: 8'h00, wgt_adr: 8'h10, count: 8'd4, dst_adr: 8'h20};
        run_single(job, 1'b0);
        job = '{src_adr: 8'h00, wgt_adr: 8'h14, count: 8'd4, dst_adr: 8'h21};
        run_single(job, 1'b1);
        job = '{src_adr: 8'h00, wgt_adr: 8'h18, count: 8'd0, dst_adr: 8'h22};
        run_single(job, 1'b0);
        run_contention(adrs[0]);

        sva_fails = u_dut.u_sva.fail_count;
        $display("Check errors: %0d, assertion failures: %0d", errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
